/* Makefile */
# Verilator build and run for the countdown timer

TOP       ?= countdown_timer_tb
FILELIST  ?= build.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the output holds the pass line
run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
design/timer_pkg.sv
design/button_sync.sv
design/tick_gen.sv
design/countdown_fsm.sv
design/seconds_counter.sv
design/bcd_display.sv
design/countdown_timer.sv
dv/countdown_checker.sv
dv/countdown_timer_tb.sv

/* design/bcd_display.sv */
// binary to bcd display digits
`timescale 1ns/100ps
`default_nettype none

module bcd_display
    import timer_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [sec_w-1:0] seconds,
    output display_t         digits
);

    display_t digits_nxt;

    // ------------------------------
    // shift and add three
    // ------------------------------
    function automatic display_t to_bcd(input logic [sec_w-1:0] bin);
        // digits on top, binary shifted out of the bottom
        logic [disp_w+sec_w-1:0] shreg;
        shreg = '0;
        shreg[sec_w-1:0] = bin;
        for (int i = 0; i < sec_w; i++) begin
            // correct every digit before the shift
            for (int d = 0; d < digit_cnt; d++) begin
                if (shreg[sec_w + d*digit_w +: digit_w] > digit_w'(4)) begin
                    shreg[sec_w + d*digit_w +: digit_w] =
                        shreg[sec_w + d*digit_w +: digit_w] + digit_w'(3);
                end
            end
            shreg = shreg << 1;
        end
        return display_t'(shreg[sec_w +: disp_w]);
    endfunction

    assign digits_nxt = to_bcd(seconds);

    // ------------------------------
    // output register
    // ------------------------------
    // one cycle behind seconds
    always_ff @(posedge clk) begin : disp_blk
        if (rst) begin
            digits <= '0;
        end else begin
            digits <= digits_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/button_sync.sv */
// button synchronizers
`timescale 1ns/100ps
`default_nettype none

module button_sync (
    input  logic clk,
    input  logic rst,
    input  logic start_btn,
    input  logic stop_btn,
    output logic start_pulse,
    output logic stop_level
);

    // ------------------------------
    // two-flop synchronizers
    // ------------------------------
    logic start_meta;
    logic start_sync;
    // previous synchronized start, for edge detect
    logic start_prev;
    logic stop_meta;
    logic stop_sync;

    always_ff @(posedge clk) begin : sync_blk
        if (rst) begin
            start_meta <= 1'b0;
            start_sync <= 1'b0;
            start_prev <= 1'b0;
            stop_meta  <= 1'b0;
            stop_sync  <= 1'b0;
        end else begin
            start_meta <= start_btn;
            start_sync <= start_meta;
            start_prev <= start_sync;
            stop_meta  <= stop_btn;
            stop_sync  <= stop_meta;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    // one cycle per press, on the rising edge only
    assign start_pulse = start_sync & ~start_prev;
    // stop acts as a plain level
    assign stop_level  = stop_sync;

endmodule

`default_nettype wire

/* design/countdown_fsm.sv */
// countdown controller
`timescale 1ns/100ps
`default_nettype none

module countdown_fsm
    import timer_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start_pulse,
    input  logic          stop_level,
    input  logic          tick,
    input  logic          zero_next,
    input  logic          sec_nonzero,
    output logic          load,
    output logic          count_en,
    output logic          dec,
    output timer_status_t status,
    output logic          time_elapsed
);

    timer_state_e state;
    timer_state_e state_nxt;

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk) begin : state_blk
        if (rst) begin
            state        <= st_idle;
            time_elapsed <= 1'b0;
        end else begin
            state        <= state_nxt;
            // rises with seconds_out reaching zero
            time_elapsed <= (state_nxt == st_elapsed);
        end
    end

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin : next_blk
        state_nxt = state;
        case (state)
            st_idle: begin
                // zero count: start ignored
                if (start_pulse && sec_nonzero) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // stop has priority over the tick
                if (stop_level) begin
                    state_nxt = st_pause;
                end else if (tick && zero_next) begin
                    // this tick takes the count to zero
                    state_nxt = st_elapsed;
                end
            end
            st_pause: begin
                if (!stop_level) begin
                    state_nxt = st_run;
                end
            end
            st_elapsed: begin
                // only rst leaves here
                state_nxt = st_elapsed;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // ------------------------------
    // control outputs
    // ------------------------------
    // load strobe in the idle to run cycle
    assign load     = (state == st_idle) & start_pulse & sec_nonzero;
    // prescaler runs only while counting down
    // stop cycle in run counts as paused, so no second is lost
    assign count_en = (state == st_run) & ~stop_level;
    // one decrement per tick
    assign dec      = (state == st_run) & tick;

    // status decoded from the state register
    always_comb begin : status_blk
        status.running = (state == st_run);
        status.paused  = (state == st_pause);
        status.elapsed = time_elapsed;
        status.state   = state;
    end

endmodule

`default_nettype wire

/* design/countdown_timer.sv */
// countdown timer top level
`timescale 1ns/100ps
`default_nettype none

module countdown_timer
    import timer_pkg::*;
#(
    // clock cycles per second, board specific
    parameter int unsigned tick_cycles = 100000000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_btn,
    input  logic             stop_btn,
    input  logic [sec_w-1:0] sec_to_count,
    output logic [sec_w-1:0] seconds_out,
    output display_t         digits,
    output timer_status_t    status,
    output logic             time_elapsed
);

    // ------------------------------
    // internal nets
    // ------------------------------
    logic start_pulse;
    logic stop_level;
    logic load;
    logic count_en;
    logic dec;
    logic tick;
    logic zero_next;
    // start only with something to count
    logic sec_nonzero;

    assign sec_nonzero = |sec_to_count;

    // async buttons into the clock domain
    button_sync button_sync_i (
        .clk         (clk),
        .rst         (rst),
        .start_btn   (start_btn),
        .stop_btn    (stop_btn),
        .start_pulse (start_pulse),
        .stop_level  (stop_level)
    );

    // one second prescaler
    tick_gen #(
        .tick_cycles (tick_cycles)
    ) tick_gen_i (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .count_en (count_en),
        .tick     (tick)
    );

    countdown_fsm countdown_fsm_i (
        .clk          (clk),
        .rst          (rst),
        .start_pulse  (start_pulse),
        .stop_level   (stop_level),
        .tick         (tick),
        .zero_next    (zero_next),
        .sec_nonzero  (sec_nonzero),
        .load         (load),
        .count_en     (count_en),
        .dec          (dec),
        .status       (status),
        .time_elapsed (time_elapsed)
    );

    seconds_counter seconds_counter_i (
        .clk          (clk),
        .rst          (rst),
        .sec_to_count (sec_to_count),
        .load         (load),
        .dec          (dec),
        .seconds_out  (seconds_out),
        .zero_next    (zero_next)
    );

    // display digits, one cycle behind seconds_out
    bcd_display bcd_display_i (
        .clk     (clk),
        .rst     (rst),
        .seconds (seconds_out),
        .digits  (digits)
    );

endmodule

`default_nettype wire

/* design/seconds_counter.sv */
// remaining seconds register
`timescale 1ns/100ps
`default_nettype none

module seconds_counter
    import timer_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [sec_w-1:0] sec_to_count,
    input  logic             load,
    input  logic             dec,
    output logic [sec_w-1:0] seconds_out,
    output logic             zero_next
);

    logic sec_zero;

    assign sec_zero = (seconds_out == '0);

    // ------------------------------
    // seconds register
    // ------------------------------
    always_ff @(posedge clk) begin : sec_blk
        if (rst) begin
            seconds_out <= '0;
        end else if (load) begin
            seconds_out <= sec_to_count;
        end else if (dec && !sec_zero) begin
            // saturates at zero
            seconds_out <= seconds_out - 1'b1;
        end
    end

    // ------------------------------
    // last second flag
    // ------------------------------
    // next decrement ends the countdown
    assign zero_next = (seconds_out == sec_w'(1));

endmodule

`default_nettype wire

/* design/tick_gen.sv */
// one second prescaler
`timescale 1ns/100ps
`default_nettype none

module tick_gen #(
    // clock cycles per second
    parameter int unsigned tick_cycles = 100000000
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic count_en,
    output logic tick
);

    // wide enough to hold tick_cycles - 1
    localparam int cnt_w = $clog2(tick_cycles + 1);

    logic [cnt_w-1:0] cnt;
    logic             cnt_last;

    // last enabled cycle of the current second
    assign cnt_last = (cnt == cnt_w'(tick_cycles - 1));

    // ------------------------------
    // cycle counter
    // ------------------------------
    always_ff @(posedge clk) begin : cnt_blk
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            // new countdown starts a fresh second
            cnt <= '0;
        end else if (count_en) begin
            if (cnt_last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
        // disabled: hold, keeps the partial second across a pause
    end

    // ------------------------------
    // tick output
    // ------------------------------
    // one cycle wide, only on an enabled cycle
    assign tick = count_en & cnt_last;

endmodule

`default_nettype wire

/* design/timer_pkg.sv */
// countdown timer definitions
`default_nettype none

package timer_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // remaining seconds, one byte
    localparam int sec_w     = 8;
    // one bcd digit
    localparam int digit_w   = 4;
    // hundreds, tens, ones
    localparam int digit_cnt = 3;
    localparam int disp_w    = digit_cnt * digit_w;

    // ------------------------------
    // controller states
    // ------------------------------
    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_run     = 2'b01,
        st_pause   = 2'b10,
        st_elapsed = 2'b11
    } timer_state_e;

    // status seen by the host
    typedef struct packed {
        logic         running;
        logic         paused;
        logic         elapsed;
        timer_state_e state;
    } timer_status_t;

    // display digits, msb digit first
    typedef struct packed {
        logic [digit_w-1:0] hundreds;
        logic [digit_w-1:0] tens;
        logic [digit_w-1:0] ones;
    } display_t;

endpackage

`default_nettype wire

/* dv/countdown_checker.sv */
// countdown timer checker
`timescale 1ns/100ps
`default_nettype none

module countdown_checker
    import timer_pkg::*;
#(
    parameter int unsigned tick_cycles = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_btn,
    input  logic             stop_btn,
    input  logic [sec_w-1:0] sec_to_count,
    input  logic [sec_w-1:0] seconds_out,
    input  display_t         digits,
    input  timer_status_t    status,
    input  logic             time_elapsed,
    output int               check_count,
    output int               error_count
);

    int checks = 0;
    int errors = 0;

    // button history, one stage per sampled edge
    logic start_d1, start_d2, start_d3;
    logic stop_d1, stop_d2;
    // expected controller state
    timer_state_e m_state;
    int unsigned  loaded;
    int unsigned  ticks_done;
    int unsigned  run_cnt;
    // seconds_out one cycle back, for the display
    logic [sec_w-1:0] prev_sec;

    assign check_count = checks;
    assign error_count = errors;

    // ------------------------------
    // reference rules
    // ------------------------------
    function automatic display_t bcd_of(input int value);
        display_t d;
        d.hundreds = digit_w'(value / 100);
        d.tens     = digit_w'((value / 10) % 10);
        d.ones     = digit_w'(value % 10);
        return d;
    endfunction

    // remaining seconds after some ticks, floor at zero
    function automatic int unsigned count_after(input int unsigned start_val,
                                                input int unsigned ticks);
        return (ticks >= start_val) ? 0 : start_val - ticks;
    endfunction

    task automatic expect_eq(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // compare and step the model
    // ------------------------------
    always @(posedge clk) begin : model_blk
        logic pulse;
        logic counting;
        logic tick_now;
        // start pulse and stop level as the synchronizers deliver them
        pulse    = start_d2 & ~start_d3;
        counting = (m_state == st_run) && !stop_d2;
        tick_now = counting && (run_cnt + 1 == tick_cycles);
        if (!rst) begin
            expect_eq("seconds_out", int'(seconds_out), int'(count_after(loaded, ticks_done)));
            expect_eq("digits", int'(digits), int'(bcd_of(int'(prev_sec))));
            expect_eq("status.state", int'(status.state), int'(m_state));
            expect_eq("status.running", int'(status.running), int'(m_state == st_run));
            expect_eq("status.paused", int'(status.paused), int'(m_state == st_pause));
            expect_eq("status.elapsed", int'(status.elapsed), int'(m_state == st_elapsed));
            expect_eq("time_elapsed", int'(time_elapsed), int'(m_state == st_elapsed));
        end
        if (rst) begin
            {start_d1, start_d2, start_d3, stop_d1, stop_d2} <= '0;
            m_state    <= st_idle;
            loaded     <= 0;
            ticks_done <= 0;
            run_cnt    <= 0;
            prev_sec   <= '0;
        end else begin
            start_d1 <= start_btn;
            start_d2 <= start_d1;
            start_d3 <= start_d2;
            stop_d1  <= stop_btn;
            stop_d2  <= stop_d1;
            prev_sec <= seconds_out;
            case (m_state)
                st_idle: begin
                    // zero count ignores the press
                    if (pulse && sec_to_count != '0) begin
                        m_state    <= st_run;
                        loaded     <= int'(sec_to_count);
                        ticks_done <= 0;
                        run_cnt    <= 0;
                    end
                end
                st_run: begin
                    if (stop_d2) begin
                        m_state <= st_pause;
                    end else if (tick_now) begin
                        run_cnt    <= 0;
                        ticks_done <= ticks_done + 1;
                        if (count_after(loaded, ticks_done + 1) == 0) begin
                            m_state <= st_elapsed;
                        end
                    end else begin
                        run_cnt <= run_cnt + 1;
                    end
                end
                st_pause: begin
                    // partial second kept in run_cnt
                    if (!stop_d2) begin
                        m_state <= st_run;
                    end
                end
                default: begin
                    m_state <= st_elapsed;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* dv/countdown_timer_tb.sv */
// countdown timer testbench
`timescale 1ns/100ps
`default_nettype none

module countdown_timer_tb
    import timer_pkg::*;
();

    localparam int tick_cycles  = 8;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int num_tests    = 6;

    logic             clk;
    logic             rst;
    logic             start_btn;
    logic             stop_btn;
    logic [sec_w-1:0] sec_to_count;
    logic [sec_w-1:0] seconds_out;
    display_t         digits;
    timer_status_t    status;
    logic             time_elapsed;
    int               check_count;
    int               error_count;

    logic [15:0] lfsr_state;
    int          secs [num_tests];
    int          pause_wait [num_tests];
    int          pause_len [num_tests];
    int          cycle_count = 0;
    int          cycle_limit = 0;

    countdown_timer #(.tick_cycles(tick_cycles)) countdown_timer_i (
        .clk (clk), .rst (rst), .start_btn (start_btn), .stop_btn (stop_btn),
        .sec_to_count (sec_to_count), .seconds_out (seconds_out),
        .digits (digits), .status (status), .time_elapsed (time_elapsed)
    );

    countdown_checker #(.tick_cycles(tick_cycles)) countdown_checker_i (
        .clk (clk), .rst (rst), .start_btn (start_btn), .stop_btn (stop_btn),
        .sec_to_count (sec_to_count), .seconds_out (seconds_out),
        .digits (digits), .status (status), .time_elapsed (time_elapsed),
        .check_count (check_count), .error_count (error_count)
    );

    initial begin : clk_blk
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic press_start();
        start_btn <= 1'b1;
        wait_cycles(3);
        start_btn <= 1'b0;
    endtask

    task automatic end_run(input logic timed_out);
        $display("summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timed_out ? 1 : 0);
        if (!timed_out && error_count == 0 && check_count > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin : timeout_blk
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            end_run(1'b1);
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : main_blk
        int v;
        int total;
        rst          = 1'b1;
        start_btn    = 1'b0;
        stop_btn     = 1'b0;
        sec_to_count = '0;
        lfsr_state   = 16'd80;
        // zero start test budget
        total = 20;
        for (int t = 0; t < num_tests; t++) begin
            draw_bits(5, v);
            secs[t] = v % 20 + 1;
            draw_bits(4, v);
            pause_wait[t] = v;
            draw_bits(5, v);
            pause_len[t] = v + 4;
            total += secs[t] * tick_cycles + pause_len[t] + 20;
        end
        cycle_limit = 2 * total + reset_cycles;
        wait_cycles(reset_cycles);
        rst <= 1'b0;
        // zero count press stays idle
        wait_cycles(2);
        press_start();
        wait_cycles(8);
        for (int t = 0; t < num_tests; t++) begin
            rst <= 1'b1;
            wait_cycles(2);
            rst          <= 1'b0;
            sec_to_count <= sec_w'(secs[t]);
            wait_cycles(1);
            press_start();
            wait_cycles(pause_wait[t]);
            stop_btn <= 1'b1;
            wait_cycles(pause_len[t]);
            stop_btn <= 1'b0;
            while (!time_elapsed) @(posedge clk);
            // press while elapsed is ignored
            press_start();
            wait_cycles(8);
        end
        end_run(1'b0);
    end

endmodule

`default_nettype wire
